// ==== design/if_pkg.sv ====
package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////////////////////

  // Byte address on the fetch path
  typedef logic [31:0] addr_t;

  // Raw 32-bit instruction word as returned by memory
  typedef logic [31:0] instr_t;

  // Upper bits of mtvec, the low seven bits of the base are zero
  typedef logic [24:0] mtvec_base_t;

  // Vectored interrupt index
  typedef logic [4:0] irq_index_t;

  // Fetch bookkeeping counts, range 0 to 3
  typedef logic [1:0] fetch_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // Next-PC sources
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch depth and executable region
  ////////////////////////////////////////////////////////////////////////////

  // Fetches in flight plus buffered responses never exceed this
  localparam int unsigned FETCH_DEPTH = 3;

  // Single executable region, both bounds inclusive
  localparam addr_t EXEC_REGION_START = 32'h0000_0000;
  localparam addr_t EXEC_REGION_END   = 32'h0000_FFFF;

endpackage

// ==== design/if_pc_mux.sv ====
module if_pc_mux import if_pkg::*; (
  input  pc_mux_e     pc_mux_i,
  input  logic        pc_set_i,
  input  addr_t       boot_addr_i,
  input  addr_t       jump_target_i,
  input  addr_t       branch_target_i,
  input  addr_t       mepc_i,
  input  mtvec_base_t mtvec_addr_i,
  input  irq_index_t  irq_index_i,
  output addr_t       branch_addr_o,
  output logic        csr_mtvec_init_o
);

  // Next fetch address
  always_comb begin
    // Boot address as fallback for unknown encodings
    branch_addr_o = {boot_addr_i[31:2], 2'b00};
    unique case (pc_mux_i)
      PC_BOOT: begin
        branch_addr_o = {boot_addr_i[31:2], 2'b00};
      end
      PC_JUMP: begin
        branch_addr_o = jump_target_i;
      end
      PC_BRANCH: begin
        branch_addr_o = branch_target_i;
      end
      // Return to the interrupted or faulting instruction
      PC_MRET: begin
        branch_addr_o = mepc_i;
      end
      // All exceptions share the vector base
      PC_TRAP_EXC: begin
        branch_addr_o = {mtvec_addr_i, 7'h00};
      end
      // Base plus four times the interrupt index
      PC_TRAP_IRQ: begin
        branch_addr_o = {mtvec_addr_i, irq_index_i, 2'b00};
      end
      default: begin
        branch_addr_o = {boot_addr_i[31:2], 2'b00};
      end
    endcase
  end

  // CSR file initializes mtvec together with the boot jump
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

// ==== design/if_prefetch.sv ====
module if_prefetch import if_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  addr_t  branch_addr_i,
  input  logic   pc_set_i,
  input  logic   kill_if_i,
  input  logic   fetch_ready_i,
  input  logic   trans_ready_i,
  input  logic   resp_valid_i,
  input  instr_t resp_rdata_i,
  input  logic   resp_err_i,
  input  logic   resp_fault_i,
  output logic   fetch_valid_o,
  output addr_t  fetch_addr_o,
  output instr_t fetch_instr_o,
  output logic   fetch_err_o,
  output logic   fetch_fault_o,
  output logic   trans_valid_o,
  output addr_t  trans_addr_o,
  output logic   busy_o
);

  logic       flush;
  logic       transfer;
  logic       resp_keep;
  logic       resp_store;
  logic       pop;
  logic       buf_empty;
  logic [2:0] in_use;

  addr_t      next_addr_q;
  logic       fetch_en_q;
  fetch_cnt_t out_cnt_q;
  fetch_cnt_t buf_cnt_q;
  fetch_cnt_t discard_q;
  logic [1:0] iss_ptr_q;
  logic [1:0] rsp_ptr_q;
  logic [1:0] rd_ptr_q;

  // Shared slot ring
  // Address written at issue, response written on return, popped by IF
  addr_t  slot_addr  [FETCH_DEPTH];
  instr_t slot_instr [FETCH_DEPTH];
  logic   slot_err   [FETCH_DEPTH];
  logic   slot_fault [FETCH_DEPTH];

  function automatic logic [1:0] ptr_inc(input logic [1:0] ptr);
    ptr_inc = (ptr == 2'(FETCH_DEPTH - 1)) ? 2'd0 : ptr + 2'd1;
  endfunction

  assign flush = pc_set_i || kill_if_i;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // Discarded fetches still count until their response is back
  assign in_use        = {1'b0, out_cnt_q} + {1'b0, buf_cnt_q};
  assign trans_valid_o = fetch_en_q && !flush && (in_use < 3'(FETCH_DEPTH));
  assign trans_addr_o  = next_addr_q;
  assign transfer      = trans_valid_o && trans_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  // Responses older than the last flush are dropped here
  assign resp_keep  = resp_valid_i && (discard_q == '0);
  assign resp_store = resp_keep && !flush;
  assign buf_empty  = (buf_cnt_q == '0);

  // Empty buffer bypasses the incoming response straight to IF
  assign fetch_valid_o = !flush && (!buf_empty || resp_keep);
  assign fetch_addr_o  = slot_addr[rd_ptr_q];
  assign fetch_instr_o = buf_empty ? resp_rdata_i : slot_instr[rd_ptr_q];
  assign fetch_err_o   = buf_empty ? resp_err_i   : slot_err[rd_ptr_q];
  assign fetch_fault_o = buf_empty ? resp_fault_i : slot_fault[rd_ptr_q];
  assign pop           = fetch_valid_o && fetch_ready_i;

  assign busy_o = (out_cnt_q != '0);

  // Sequencing, counts and pointers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q  <= 1'b0;
      next_addr_q <= '0;
      out_cnt_q   <= '0;
      buf_cnt_q   <= '0;
      discard_q   <= '0;
      iss_ptr_q   <= '0;
      rsp_ptr_q   <= '0;
      rd_ptr_q    <= '0;
    end else begin
      // Fetching starts with the first redirect, normally boot
      if (pc_set_i) begin
        fetch_en_q  <= 1'b1;
        next_addr_q <= {branch_addr_i[31:2], 2'b00};
      end else if (transfer) begin
        next_addr_q <= next_addr_q + 32'd4;
      end
      out_cnt_q <= out_cnt_q + fetch_cnt_t'(transfer) - fetch_cnt_t'(resp_valid_i);
      if (flush) begin
        // Everything still outstanding after this cycle gets dropped
        discard_q <= out_cnt_q - fetch_cnt_t'(resp_valid_i);
        buf_cnt_q <= '0;
        iss_ptr_q <= '0;
        rsp_ptr_q <= '0;
        rd_ptr_q  <= '0;
      end else begin
        if (resp_valid_i && (discard_q != '0)) begin
          discard_q <= discard_q - 2'd1;
        end
        buf_cnt_q <= buf_cnt_q + fetch_cnt_t'(resp_store) - fetch_cnt_t'(pop);
        if (transfer) begin
          iss_ptr_q <= ptr_inc(iss_ptr_q);
        end
        if (resp_store) begin
          rsp_ptr_q <= ptr_inc(rsp_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
      end
    end
  end

  // Slot storage
  always_ff @(posedge clk) begin
    if (transfer) begin
      slot_addr[iss_ptr_q] <= trans_addr_o;
    end
    if (resp_store) begin
      slot_instr[rsp_ptr_q] <= resp_rdata_i;
      slot_err[rsp_ptr_q]   <= resp_err_i;
      slot_fault[rsp_ptr_q] <= resp_fault_i;
    end
  end

endmodule

// ==== design/if_region_check.sv ====
module if_region_check import if_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   core_valid_i,
  input  addr_t  core_addr_i,
  output logic   core_ready_o,
  output logic   bus_valid_o,
  output addr_t  bus_addr_o,
  input  logic   bus_ready_i,
  input  logic   bus_rvalid_i,
  input  instr_t bus_rdata_i,
  input  logic   bus_err_i,
  output logic   resp_valid_o,
  output instr_t resp_rdata_o,
  output logic   resp_err_o,
  output logic   resp_fault_o
);

  logic       in_region;
  logic       bus_xfer;
  logic       fault_accept;
  logic       fault_resp;

  logic       fault_pend_q;
  fetch_cnt_t bus_cnt_q;

  // Executable window, bounds inclusive
  assign in_region = (core_addr_i >= EXEC_REGION_START) &&
                     (core_addr_i <= EXEC_REGION_END);

  ////////////////////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////////////////////

  // Nothing new accepted until a pending fault has been answered
  assign bus_valid_o  = core_valid_i && !fault_pend_q && in_region;
  assign bus_addr_o   = core_addr_i;
  assign core_ready_o = !fault_pend_q && (in_region ? bus_ready_i : 1'b1);

  assign bus_xfer     = bus_valid_o && bus_ready_i;
  // Out-of-region fetch taken at once, never reaches the bus
  assign fault_accept = core_valid_i && core_ready_o && !in_region;

  ////////////////////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////////////////////

  // Fault answered only after all older bus fetches returned
  assign fault_resp = fault_pend_q && (bus_cnt_q == '0);

  assign resp_valid_o = bus_rvalid_i || fault_resp;
  assign resp_rdata_o = fault_resp ? '0 : bus_rdata_i;
  assign resp_err_o   = bus_rvalid_i && bus_err_i;
  assign resp_fault_o = fault_resp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fault_pend_q <= 1'b0;
      bus_cnt_q    <= '0;
    end else begin
      // Bus fetches passed on and not yet answered
      bus_cnt_q <= bus_cnt_q + fetch_cnt_t'(bus_xfer) - fetch_cnt_t'(bus_rvalid_i);
      if (fault_accept) begin
        fault_pend_q <= 1'b1;
      end else if (fault_resp) begin
        fault_pend_q <= 1'b0;
      end
    end
  end

endmodule

// ==== design/if_bus_master.sv ====
module if_bus_master import if_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   trans_valid_i,
  input  addr_t  trans_addr_i,
  output logic   trans_ready_o,
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  instr_t instr_rdata_i,
  input  logic   instr_err_i,
  output logic   rvalid_o,
  output instr_t rdata_o,
  output logic   err_o
);

  logic   accept;

  logic   req_q;
  addr_t  addr_q;
  logic   rvalid_q;
  instr_t rdata_q;
  logic   err_q;

  // New transfer only when idle or in the grant cycle
  assign trans_ready_o = !req_q || instr_gnt_i;
  assign accept        = trans_valid_i && trans_ready_o;

  // Request straight from flops, stable until granted
  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;

  // Captured response, one cycle behind the bus
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (accept) begin
        req_q <= 1'b1;
      end else if (instr_gnt_i) begin
        req_q <= 1'b0;
      end
      rvalid_q <= instr_rvalid_i;
    end
  end

  // Address and response data
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= trans_addr_i;
    end
    if (instr_rvalid_i) begin
      rdata_q <= instr_rdata_i;
      err_q   <= instr_err_i;
    end
  end

endmodule

// ==== design/if_stage.sv ====
module if_stage import if_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Redirect and trap targets
  input  pc_mux_e     pc_mux_i,
  input  logic        pc_set_i,
  input  addr_t       boot_addr_i,
  input  addr_t       jump_target_i,
  input  addr_t       branch_target_i,
  input  addr_t       mepc_i,
  input  mtvec_base_t mtvec_addr_i,
  input  irq_index_t  irq_index_i,
  // Stage control
  input  logic        kill_if_i,
  input  logic        halt_if_i,
  input  logic        trigger_match_i,
  input  logic        id_ready_i,
  // Instruction bus
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_err_i,
  // Stage status
  output addr_t       pc_if_o,
  output logic        if_valid_o,
  output logic        if_busy_o,
  output logic        csr_mtvec_init_o,
  // IF/ID register
  output logic        id_valid_o,
  output addr_t       id_pc_o,
  output instr_t      id_instr_o,
  output logic        id_bus_err_o,
  output logic        id_mpu_fault_o,
  output logic        id_abort_o
);

  addr_t  branch_addr;
  logic   if_ready;
  logic   abort;

  logic   fetch_valid;
  instr_t fetch_instr;
  logic   fetch_err;
  logic   fetch_fault;

  logic   pf_trans_valid;
  logic   pf_trans_ready;
  addr_t  pf_trans_addr;
  logic   pf_resp_valid;
  instr_t pf_resp_rdata;
  logic   pf_resp_err;
  logic   pf_resp_fault;

  logic   bus_trans_valid;
  logic   bus_trans_ready;
  addr_t  bus_trans_addr;
  logic   bus_rvalid;
  instr_t bus_rdata;
  logic   bus_err;

  if_pc_mux u_if_pc_mux (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_index_i      (irq_index_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  if_prefetch u_if_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_addr_i (branch_addr),
    .pc_set_i      (pc_set_i),
    .kill_if_i     (kill_if_i),
    .fetch_ready_i (if_ready),
    .trans_ready_i (pf_trans_ready),
    .resp_valid_i  (pf_resp_valid),
    .resp_rdata_i  (pf_resp_rdata),
    .resp_err_i    (pf_resp_err),
    .resp_fault_i  (pf_resp_fault),
    .fetch_valid_o (fetch_valid),
    .fetch_addr_o  (pc_if_o),
    .fetch_instr_o (fetch_instr),
    .fetch_err_o   (fetch_err),
    .fetch_fault_o (fetch_fault),
    .trans_valid_o (pf_trans_valid),
    .trans_addr_o  (pf_trans_addr),
    .busy_o        (if_busy_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Region check and bus master
  ////////////////////////////////////////////////////////////////////////////

  if_region_check u_if_region_check (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_valid_i (pf_trans_valid),
    .core_addr_i  (pf_trans_addr),
    .core_ready_o (pf_trans_ready),
    .bus_valid_o  (bus_trans_valid),
    .bus_addr_o   (bus_trans_addr),
    .bus_ready_i  (bus_trans_ready),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata),
    .bus_err_i    (bus_err),
    .resp_valid_o (pf_resp_valid),
    .resp_rdata_o (pf_resp_rdata),
    .resp_err_o   (pf_resp_err),
    .resp_fault_o (pf_resp_fault)
  );

  if_bus_master u_if_bus_master (
    .clk            (clk),
    .rst_n          (rst_n),
    .trans_valid_i  (bus_trans_valid),
    .trans_addr_i   (bus_trans_addr),
    .trans_ready_o  (bus_trans_ready),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .rvalid_o       (bus_rvalid),
    .rdata_o        (bus_rdata),
    .err_o          (bus_err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // IF handshake and IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  // Kill drains the stage, halt freezes it
  assign if_valid_o = fetch_valid && !kill_if_i && !halt_if_i;
  assign if_ready   = kill_if_i || (id_ready_i && !halt_if_i);

  // Known exception or trigger makes ID drop the instruction
  assign abort = fetch_err || fetch_fault || trigger_match_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o     <= 1'b0;
      id_bus_err_o   <= 1'b0;
      id_mpu_fault_o <= 1'b0;
      id_abort_o     <= 1'b0;
    end else if (if_valid_o && id_ready_i) begin
      id_valid_o     <= 1'b1;
      id_bus_err_o   <= fetch_err;
      id_mpu_fault_o <= fetch_fault;
      id_abort_o     <= abort;
    end else if (id_ready_i) begin
      // ID consumed its entry and nothing new arrives
      id_valid_o <= 1'b0;
    end
  end

  // PC and instruction word, frozen while ID stalls
  always_ff @(posedge clk) begin
    if (if_valid_o && id_ready_i) begin
      id_pc_o    <= pc_if_o;
      id_instr_o <= fetch_instr;
    end
  end

endmodule

// ==== dv/if_stage_checker.sv ====
module if_stage_checker import if_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input pc_mux_e     pc_mux_i,
  input logic        pc_set_i,
  input addr_t       boot_addr_i,
  input addr_t       jump_target_i,
  input addr_t       branch_target_i,
  input addr_t       mepc_i,
  input mtvec_base_t mtvec_addr_i,
  input irq_index_t  irq_index_i,
  input logic        kill_if_i,
  input logic        halt_if_i,
  input logic        trigger_match_i,
  input logic        id_ready_i,
  input logic        instr_req_o,
  input addr_t       instr_addr_o,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i,
  input addr_t       pc_if_o,
  input logic        if_valid_o,
  input logic        if_busy_o,
  input logic        csr_mtvec_init_o,
  input logic        id_valid_o,
  input addr_t       id_pc_o,
  input instr_t      id_instr_o,
  input logic        id_bus_err_o,
  input logic        id_mpu_fault_o,
  input logic        id_abort_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Memory model constants, same as in the testbench
  localparam instr_t INSTR_XOR = 32'hA5A5_0000;
  localparam addr_t  ERR_ADDR  = 32'h0000_0408;

  int    fail_cnt = 0;
  int    gnt_pend;
  addr_t target;
  addr_t exp_pc;
  addr_t exp_id_pc_q;
  logic  exp_known;
  logic  check_q;
  logic  trig_q;
  logic  id_load;
  logic  exp_fault;
  logic  exp_err;

  assign id_load   = if_valid_o && id_ready_i;
  assign exp_fault = exp_id_pc_q > EXEC_REGION_END;
  assign exp_err   = exp_id_pc_q == ERR_ADDR;

  ////////////////////////////////////////////////////////////////////////////
  // Reference PC model
  ////////////////////////////////////////////////////////////////////////////

  // Redirect target per source
  always_comb begin
    case (pc_mux_i)
      PC_BOOT:     target = boot_addr_i;
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      PC_MRET:     target = mepc_i;
      PC_TRAP_EXC: target = addr_t'(mtvec_addr_i) << 7;
      default:     target = (addr_t'(mtvec_addr_i) << 7) + (addr_t'(irq_index_i) << 2);
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_known   <= 1'b0;
      exp_pc      <= '0;
      exp_id_pc_q <= '0;
      check_q     <= 1'b0;
      trig_q      <= 1'b0;
      gnt_pend    <= 0;
    end else begin
      // One check per IF/ID load, done in the cycle after
      check_q <= id_load && exp_known;
      if (id_load) begin
        exp_id_pc_q <= exp_pc;
        trig_q      <= trigger_match_i;
      end
      // Fetches are word aligned
      if (pc_set_i) begin
        exp_known <= 1'b1;
        exp_pc    <= target & ~32'h3;
      end else if (kill_if_i) begin
        // Kill without redirect resumes at an unknown point
        exp_known <= 1'b0;
      end else if (id_load) begin
        exp_pc <= exp_pc + 32'd4;
      end
      // Granted requests still waiting for rvalid
      gnt_pend <= gnt_pend + int'(instr_req_o && instr_gnt_i) - int'(instr_rvalid_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF side status
  ////////////////////////////////////////////////////////////////////////////

  // Offered word belongs to the next expected PC
  a_pc_if: assert property (@(posedge clk) disable iff (!rst_n)
    if_valid_o && exp_known |-> pc_if_o == exp_pc)
    else begin
      $error("FAIL pc_if_o got %h expected %h", pc_if_o, exp_pc);
      fail_cnt++;
    end

  // Request on the bus or response still owed keeps the stage busy
  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o || (gnt_pend != 0)) |-> if_busy_o)
    else begin
      $error("FAIL if_busy_o got %h expected %h", if_busy_o, 1'b1);
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID contents
  ////////////////////////////////////////////////////////////////////////////

  a_id_pc: assert property (@(posedge clk) disable iff (!rst_n)
    check_q |-> id_pc_o == exp_id_pc_q)
    else begin
      $error("FAIL id_pc_o got %h expected %h", id_pc_o, exp_id_pc_q);
      fail_cnt++;
    end

  // Faulted and errored words carry no valid data
  a_id_instr: assert property (@(posedge clk) disable iff (!rst_n)
    check_q && !exp_fault && !exp_err |-> id_instr_o == (exp_id_pc_q ^ INSTR_XOR))
    else begin
      $error("FAIL id_instr_o got %h expected %h", id_instr_o, exp_id_pc_q ^ INSTR_XOR);
      fail_cnt++;
    end

  a_mpu_fault: assert property (@(posedge clk) disable iff (!rst_n)
    check_q |-> id_mpu_fault_o == exp_fault)
    else begin
      $error("FAIL id_mpu_fault_o got %h expected %h", id_mpu_fault_o, exp_fault);
      fail_cnt++;
    end

  a_bus_err: assert property (@(posedge clk) disable iff (!rst_n)
    check_q |-> id_bus_err_o == exp_err)
    else begin
      $error("FAIL id_bus_err_o got %h expected %h", id_bus_err_o, exp_err);
      fail_cnt++;
    end

  a_abort: assert property (@(posedge clk) disable iff (!rst_n)
    check_q |-> id_abort_o == (exp_fault || exp_err || trig_q))
    else begin
      $error("FAIL id_abort_o got %h expected %h", id_abort_o,
             exp_fault || exp_err || trig_q);
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Bus protocol and flow control
  ////////////////////////////////////////////////////////////////////////////

  a_no_req_outside: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o |-> instr_addr_o <= EXEC_REGION_END)
    else begin
      $error("instruction bus request issued outside the executable region");
      fail_cnt++;
    end

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      $error("ungranted request dropped or changed its address");
      fail_cnt++;
    end

  a_max_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    gnt_pend + int'(instr_req_o) <= 3)
    else begin
      $error("more than three fetches outstanding on the instruction bus");
      fail_cnt++;
    end

  a_id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_o && !id_ready_i |=>
      $stable({id_valid_o, id_pc_o, id_instr_o, id_bus_err_o, id_mpu_fault_o, id_abort_o}))
    else begin
      $error("IF/ID register changed while ID was stalled");
      fail_cnt++;
    end

  a_kill_halt: assert property (@(posedge clk) disable iff (!rst_n)
    kill_if_i || halt_if_i |-> !if_valid_o)
    else begin
      $error("if_valid_o high during kill or halt");
      fail_cnt++;
    end

  a_mtvec_init: assert property (@(posedge clk) disable iff (!rst_n)
    csr_mtvec_init_o == (pc_set_i && pc_mux_i == PC_BOOT))
    else begin
      $error("FAIL csr_mtvec_init_o got %h expected %h", csr_mtvec_init_o,
             pc_set_i && pc_mux_i == PC_BOOT);
      fail_cnt++;
    end

endmodule

// ==== dv/tb_if_stage.sv ====
module tb_if_stage import if_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam instr_t INSTR_XOR    = 32'hA5A5_0000;
  localparam addr_t  ERR_ADDR     = 32'h0000_0408;
  localparam int     LOAD_TIMEOUT = 400;

  logic        clk;
  logic        rst_n;
  pc_mux_e     pc_mux_i;
  logic        pc_set_i;
  addr_t       boot_addr_i;
  addr_t       jump_target_i;
  addr_t       branch_target_i;
  addr_t       mepc_i;
  mtvec_base_t mtvec_addr_i;
  irq_index_t  irq_index_i;
  logic        kill_if_i;
  logic        halt_if_i;
  logic        trigger_match_i;
  logic        id_ready_i     = 1'b1;
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_gnt_i    = 1'b0;
  logic        instr_rvalid_i = 1'b0;
  instr_t      instr_rdata_i  = '0;
  logic        instr_err_i    = 1'b0;
  addr_t       pc_if_o;
  logic        if_valid_o;
  logic        if_busy_o;
  logic        csr_mtvec_init_o;
  logic        id_valid_o;
  addr_t       id_pc_o;
  instr_t      id_instr_o;
  logic        id_bus_err_o;
  logic        id_mpu_fault_o;
  logic        id_abort_o;

  logic        stall_en = 1'b0;
  int          load_cnt = 0;
  int          rsp_wait = 0;
  addr_t       rsp_addr;
  addr_t       pend_addr [$];

  if_stage u_if_stage (.*);

  bind if_stage if_stage_checker u_if_stage_checker (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  // Single-cycle redirect pulse
  task automatic redirect(input pc_mux_e src);
    pc_mux_i <= src;
    pc_set_i <= 1'b1;
    @(posedge clk);
    pc_set_i <= 1'b0;
  endtask

  task automatic wait_loads(input int n);
    int start;
    int cycles;
    start  = load_cnt;
    cycles = 0;
    while ((load_cnt - start) < n) begin
      if (cycles >= LOAD_TIMEOUT) begin
        stop_on_error($sformatf("timeout waiting for %0d instruction loads into ID", n));
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model, random grant and response delay
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      pend_addr.delete();
      rsp_wait = 0;
    end else begin
      // Handover seen on the edge that ends the cycle
      if (instr_req_o && instr_gnt_i) begin
        pend_addr.push_back(instr_addr_o);
      end
      instr_gnt_i    <= ($urandom % 4) != 0;
      instr_rvalid_i <= 1'b0;
      if (rsp_wait > 0) begin
        rsp_wait--;
      end else if (pend_addr.size() > 0) begin
        rsp_addr = pend_addr.pop_front();
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= rsp_addr ^ INSTR_XOR;
        instr_err_i    <= rsp_addr == ERR_ADDR;
        rsp_wait = $urandom % 3;
      end
    end
  end

  // Random ID stall gaps
  always @(posedge clk) begin
    id_ready_i <= stall_en ? (($urandom % 4) != 0) : 1'b1;
  end

  // Progress counter for the waits
  always @(posedge clk) begin
    if (rst_n && if_valid_o && id_ready_i) begin
      load_cnt <= load_cnt + 1;
    end
  end

  always @(posedge clk) begin
    if (u_if_stage.u_if_stage_checker.fail_cnt != 0) begin
      stop_on_error("checker assertion failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h1ecc2219));
    rst_n           = 1'b0;
    pc_mux_i        = PC_BOOT;
    pc_set_i        = 1'b0;
    // Boot address low bits get cleared
    boot_addr_i     = 32'h0000_0082;
    jump_target_i   = 32'h0000_0400;
    branch_target_i = 32'h0000_0500;
    mepc_i          = 32'h0000_3000;
    mtvec_addr_i    = 25'h00_0040;
    irq_index_i     = 5'd7;
    kill_if_i       = 1'b0;
    halt_if_i       = 1'b0;
    trigger_match_i = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    redirect(PC_BOOT);
    wait_loads(8);
    stall_en <= 1'b1;
    wait_loads(10);
    // Runs into the error address
    redirect(PC_JUMP);
    wait_loads(6);
    redirect(PC_TRAP_EXC);
    wait_loads(4);
    redirect(PC_TRAP_IRQ);
    wait_loads(4);
    redirect(PC_BRANCH);
    wait_loads(3);
    redirect(PC_MRET);
    wait_loads(3);
    // Out-of-region jump
    jump_target_i <= 32'h0002_0000;
    redirect(PC_JUMP);
    wait_loads(3);
    jump_target_i <= 32'h0000_0600;
    redirect(PC_JUMP);
    trigger_match_i <= 1'b1;
    wait_loads(2);
    trigger_match_i <= 1'b0;
    halt_if_i <= 1'b1;
    repeat (8) @(posedge clk);
    halt_if_i <= 1'b0;
    wait_loads(3);
    kill_if_i <= 1'b1;
    repeat (3) @(posedge clk);
    kill_if_i     <= 1'b0;
    jump_target_i <= 32'h0000_0700;
    redirect(PC_JUMP);
    // Back-to-back redirects drop in-flight fetches
    jump_target_i <= 32'h0000_0800;
    redirect(PC_JUMP);
    wait_loads(6);
    stall_en <= 1'b0;
    repeat (20) @(posedge clk);
    if (u_if_stage.u_if_stage_checker.fail_cnt == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "checker reported errors");
    end
  end

endmodule

// ==== if_stage.f ====
design/if_pkg.sv
design/if_pc_mux.sv
design/if_prefetch.sv
design/if_region_check.sv
design/if_bus_master.sv
design/if_stage.sv
dv/if_stage_checker.sv
dv/tb_if_stage.sv

// ==== Makefile ====
# Verilator build and run of the IF stage testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_if_stage
FILELIST  = if_stage.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000
FAIL_MSG  = TEST FAILED
PASS_MSG  = TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
